// ==== common/conv_defines.svh ====
`ifndef CONV_DEFINES_SVH
`define CONV_DEFINES_SVH

// Pixel, coefficient and result word width
`define CONV_PIXEL_W 16

// Kernel edge length, square kernel
`define CONV_KERNEL_SIZE 3

// Entries per FIFO, input and output alike
`define CONV_FIFO_DEPTH 16

// Accumulator width
// 32-bit products, nine of them, need 4 guard bits
`define CONV_ACC_W 36

`endif

// ==== common/conv_data_pkg.sv ====
`include "conv_defines.svh"

package conv_data_pkg;

    // One image pixel
    typedef logic [`CONV_PIXEL_W-1:0] pixel_t;

    // One kernel coefficient
    typedef logic [`CONV_PIXEL_W-1:0] coef_t;

    // Clipped convolution result
    typedef logic [`CONV_PIXEL_W-1:0] result_t;

    // Sum of products
    typedef logic [`CONV_ACC_W-1:0] acc_t;

    // Input FIFO entry
    // Top bit is the newline flag, low bits carry pixel or coefficient
    typedef logic [`CONV_PIXEL_W:0] in_entry_t;

endpackage

// ==== common/conv_ctrl_pkg.sv ====
`include "conv_defines.svh"

package conv_ctrl_pkg;

    // Window assembler FSM
    typedef enum logic [1:0] {
        st_idle,
        st_load_kernel,
        st_fill,
        st_stream
    } window_state_t;

    // Words taken within the kernel (0..8) or within a column (0..2)
    typedef logic [$clog2(`CONV_KERNEL_SIZE * `CONV_KERNEL_SIZE + 1)-1:0] tap_count_t;

    // FIFO fill level, 0 up to the full depth
    typedef logic [$clog2(`CONV_FIFO_DEPTH + 1)-1:0] level_t;

endpackage

// ==== verilog/conv_fifo.sv ====
`include "conv_defines.svh"

module conv_fifo #(
    parameter int WIDTH = `CONV_PIXEL_W
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  push,
    input  logic [WIDTH-1:0]      push_data,
    input  logic                  pop,
    output logic [WIDTH-1:0]      pop_data,
    output logic                  full,
    output logic                  empty,
    output conv_ctrl_pkg::level_t level
);
    localparam int DEPTH = `CONV_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             do_push;
    logic             do_pop;

    // Flags straight from the fill level
    assign full  = (level == conv_ctrl_pkg::level_t'(DEPTH));
    assign empty = (level == '0);

    // Qualified strobes, illegal requests fall away here
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // First word fall through, head entry always on the output
    assign pop_data = mem[rd_ptr];

    // Storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers and level
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves the level unchanged
            case ({do_push, do_pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    // Producer must honour full, for the output FIFO this is the window back-pressure
    a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n) push |-> !full)
        else $error("conv_fifo: push while full");

    // Consumer must honour empty
    a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n) pop |-> !empty)
        else $error("conv_fifo: pop while empty");

endmodule

// ==== convolution/conv_window.sv ====
`include "conv_defines.svh"

module conv_window (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     start,
    input  conv_data_pkg::in_entry_t in_entry,
    input  logic                     in_empty,
    output logic                     in_pop,
    input  conv_ctrl_pkg::level_t    out_level,
    output logic                     win_valid,
    output conv_data_pkg::pixel_t    win_pixels [`CONV_KERNEL_SIZE * `CONV_KERNEL_SIZE],
    output conv_data_pkg::coef_t     kernel [`CONV_KERNEL_SIZE * `CONV_KERNEL_SIZE]
);
    localparam int K    = `CONV_KERNEL_SIZE;
    localparam int TAPS = K * K;

    conv_ctrl_pkg::window_state_t state;
    conv_ctrl_pkg::tap_count_t    tap_cnt;
    conv_ctrl_pkg::tap_count_t    col_cnt;
    conv_data_pkg::pixel_t        word;
    logic                         is_newline;
    logic                         out_room;
    logic                         take_coef;
    logic                         take_pixel;
    logic                         col_done;

    // Split the entry into flag and payload
    assign is_newline = in_entry[`CONV_PIXEL_W];
    assign word       = in_entry[`CONV_PIXEL_W-1:0];

    // Keep two slots free for results still inside the MAC
    assign out_room = (out_level < conv_ctrl_pkg::level_t'(`CONV_FIFO_DEPTH - 2));

    // At most one word per cycle and none while idle
    assign in_pop = start && (state != conv_ctrl_pkg::st_idle) && !in_empty && out_room;

    assign take_coef  = in_pop && !is_newline && (state == conv_ctrl_pkg::st_load_kernel);
    assign take_pixel = in_pop && !is_newline &&
                        ((state == conv_ctrl_pkg::st_fill) ||
                         (state == conv_ctrl_pkg::st_stream));

    // Bottom word of a column
    assign col_done = take_pixel && (tap_cnt == conv_ctrl_pkg::tap_count_t'(K - 1));

    // Control FSM
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= conv_ctrl_pkg::st_idle;
            tap_cnt   <= '0;
            col_cnt   <= '0;
            win_valid <= 1'b0;
        end else begin
            win_valid <= 1'b0;
            if (!start) begin
                // Dropping start aborts whatever is in progress
                state   <= conv_ctrl_pkg::st_idle;
                tap_cnt <= '0;
                col_cnt <= '0;
            end else begin
                case (state)
                    conv_ctrl_pkg::st_idle: begin
                        state   <= conv_ctrl_pkg::st_load_kernel;
                        tap_cnt <= '0;
                    end
                    conv_ctrl_pkg::st_load_kernel: begin
                        // Newline entries skipped here
                        if (take_coef) begin
                            if (tap_cnt == conv_ctrl_pkg::tap_count_t'(TAPS - 1)) begin
                                state   <= conv_ctrl_pkg::st_fill;
                                tap_cnt <= '0;
                                col_cnt <= '0;
                            end else begin
                                tap_cnt <= tap_cnt + 1'b1;
                            end
                        end
                    end
                    conv_ctrl_pkg::st_fill,
                    conv_ctrl_pkg::st_stream: begin
                        if (in_pop && is_newline) begin
                            // New image row so the window starts empty again
                            state   <= conv_ctrl_pkg::st_fill;
                            tap_cnt <= '0;
                            col_cnt <= '0;
                        end else if (col_done) begin
                            tap_cnt <= '0;
                            if (state == conv_ctrl_pkg::st_stream) begin
                                win_valid <= 1'b1;
                            end else if (col_cnt == conv_ctrl_pkg::tap_count_t'(K - 1)) begin
                                // Third column closes the first window
                                state     <= conv_ctrl_pkg::st_stream;
                                win_valid <= 1'b1;
                            end else begin
                                col_cnt <= col_cnt + 1'b1;
                            end
                        end else if (take_pixel) begin
                            tap_cnt <= tap_cnt + 1'b1;
                        end
                    end
                    default: state <= conv_ctrl_pkg::st_idle;
                endcase
            end
        end
    end

    // Kernel and window payload
    always_ff @(posedge clk) begin
        if (take_coef) begin
            kernel[tap_cnt] <= word;
        end
        // One shift per pixel gives column-major order after each full column
        if (take_pixel) begin
            for (int i = 0; i < TAPS - 1; i++) begin
                win_pixels[i] <= win_pixels[i + 1];
            end
            win_pixels[TAPS - 1] <= word;
        end
    end

    // A new window needs room for itself and one result ahead of it in the MAC
    a_out_room: assert property (@(posedge clk) disable iff (!arst_n)
        win_valid |-> (out_level <= conv_ctrl_pkg::level_t'(`CONV_FIFO_DEPTH - 2)))
        else $error("conv_window: window issued without room in output FIFO");

endmodule

// ==== convolution/conv_mac.sv ====
`include "conv_defines.svh"

module conv_mac (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   win_valid,
    input  conv_data_pkg::pixel_t  win_pixels [`CONV_KERNEL_SIZE * `CONV_KERNEL_SIZE],
    input  conv_data_pkg::coef_t   kernel [`CONV_KERNEL_SIZE * `CONV_KERNEL_SIZE],
    output logic                   res_valid,
    output conv_data_pkg::result_t res_data
);
    localparam int TAPS = `CONV_KERNEL_SIZE * `CONV_KERNEL_SIZE;

    // Largest value a result word can hold
    localparam conv_data_pkg::acc_t RES_MAX = conv_data_pkg::acc_t'({`CONV_PIXEL_W{1'b1}});

    conv_data_pkg::acc_t prod [TAPS];
    conv_data_pkg::acc_t sum;
    logic                prod_valid;

    // Stage 1 products
    // Widened to the accumulator by the assignment context
    always_ff @(posedge clk) begin
        if (win_valid) begin
            for (int i = 0; i < TAPS; i++) begin
                prod[i] <= win_pixels[i] * kernel[i];
            end
        end
    end

    // Flat sum of the nine products
    always_comb begin
        sum = '0;
        for (int i = 0; i < TAPS; i++) begin
            sum = sum + prod[i];
        end
    end

    // Stage 2 clip to 16 bits
    always_ff @(posedge clk) begin
        if (prod_valid) begin
            res_data <= (sum > RES_MAX) ? {`CONV_PIXEL_W{1'b1}} : sum[`CONV_PIXEL_W-1:0];
        end
    end

    // Valid pipe alongside the data
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prod_valid <= 1'b0;
            res_valid  <= 1'b0;
        end else begin
            prod_valid <= win_valid;
            res_valid  <= prod_valid;
        end
    end

    // Every window gives a result two cycles later
    a_latency: assert property (@(posedge clk) disable iff (!arst_n)
        win_valid |-> ##2 res_valid)
        else $error("conv_mac: result missing two cycles after window");

    // A centre product past full scale must come out clipped
    a_clip: assert property (@(posedge clk) disable iff (!arst_n)
        win_valid && (win_pixels[TAPS / 2] * kernel[TAPS / 2] > RES_MAX)
        |-> ##2 (res_data == '1))
        else $error("conv_mac: oversized product not clipped");

endmodule

// ==== verilog/conv_accelerator.sv ====
`include "conv_defines.svh"

module conv_accelerator (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   start,
    input  logic                   wr,
    input  logic                   newline,
    input  conv_data_pkg::pixel_t  data_in,
    input  logic                   rd,
    output conv_data_pkg::result_t data_out,
    output logic                   full_in,
    output logic                   empty_in,
    output logic                   full_out,
    output logic                   empty_out
);
    localparam int TAPS = `CONV_KERNEL_SIZE * `CONV_KERNEL_SIZE;

    logic                     in_push;
    conv_data_pkg::in_entry_t in_wdata;
    conv_data_pkg::in_entry_t in_entry;
    logic                     in_pop;
    conv_ctrl_pkg::level_t    out_level;
    logic                     win_valid;
    conv_data_pkg::pixel_t    win_pixels [TAPS];
    conv_data_pkg::coef_t     kernel [TAPS];
    logic                     res_valid;
    conv_data_pkg::result_t   res_data;

    // Newline wins over a data write in the same cycle
    assign in_push  = wr || newline;
    assign in_wdata = {newline, data_in};

    // Kernel words, pixels and newline markers in arrival order
    conv_fifo #(
        .WIDTH ($bits(conv_data_pkg::in_entry_t))
    ) u_in_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (in_push),
        .push_data (in_wdata),
        .pop       (in_pop),
        .pop_data  (in_entry),
        .full      (full_in),
        .empty     (empty_in),
        .level     ()
    );

    conv_window u_window (
        .clk        (clk),
        .arst_n     (arst_n),
        .start      (start),
        .in_entry   (in_entry),
        .in_empty   (empty_in),
        .in_pop     (in_pop),
        .out_level  (out_level),
        .win_valid  (win_valid),
        .win_pixels (win_pixels),
        .kernel     (kernel)
    );

    conv_mac u_mac (
        .clk        (clk),
        .arst_n     (arst_n),
        .win_valid  (win_valid),
        .win_pixels (win_pixels),
        .kernel     (kernel),
        .res_valid  (res_valid),
        .res_data   (res_data)
    );

    // Results until the host reads them
    conv_fifo #(
        .WIDTH ($bits(conv_data_pkg::result_t))
    ) u_out_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (res_valid),
        .push_data (res_data),
        .pop       (rd),
        .pop_data  (data_out),
        .full      (full_out),
        .empty     (empty_out),
        .level     (out_level)
    );

endmodule

// ==== verif/conv_accelerator_tb.sv ====
`include "conv_defines.svh"

module conv_accelerator_tb;
    localparam int K       = `CONV_KERNEL_SIZE;
    localparam int TAPS    = K * K;
    localparam int N_TESTS = 5;
    // Pixel modes
    localparam int PIX_RANDOM = 0;
    localparam int PIX_CONST  = 1;
    localparam int PIX_RAMP   = 2;

    logic                   clk;
    logic                   arst_n;
    logic                   start;
    logic                   wr;
    logic                   newline;
    conv_data_pkg::pixel_t  data_in;
    logic                   rd;
    conv_data_pkg::result_t data_out;
    logic                   full_in;
    logic                   empty_in;
    logic                   full_out;
    logic                   empty_out;

    // Test table with one entry per row
    string                 t_name  [N_TESTS];
    conv_data_pkg::coef_t  t_kern  [N_TESTS][TAPS];
    int                    t_w     [N_TESTS];
    int                    t_h     [N_TESTS];
    int                    t_mode  [N_TESTS];
    int                    t_drain [N_TESTS];

    conv_data_pkg::pixel_t  img [8][32];
    conv_data_pkg::result_t exp_q [$];
    string                  cur_test;
    int                     errors;
    int                     n_pass;
    int                     n_fail;
    int                     limit_cycles;
    logic                   saw_full_in;

    conv_accelerator dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (start),
        .wr        (wr),
        .newline   (newline),
        .data_in   (data_in),
        .rd        (rd),
        .data_out  (data_out),
        .full_in   (full_in),
        .empty_in  (empty_in),
        .full_out  (full_out),
        .empty_out (empty_out)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Watchdog armed once the table length is known
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", limit_cycles);
        $display("=== FAIL ===");
        $finish;
    end

    task automatic check_result(input string name, input conv_data_pkg::result_t got,
                                input conv_data_pkg::result_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s: %s got 0x%h, expected 0x%h", cur_test, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s: %s got 0x%h, expected 0x%h", cur_test, name, got, exp);
            errors++;
        end
    endtask

    task automatic build_table();
        int i;
        t_name = '{"identity", "general", "saturation", "newline", "backpressure"};
        t_w     = '{5, 4, 4, 6, 28};
        t_h     = '{5, 6, 4, 4, 3};
        t_mode  = '{PIX_RANDOM, PIX_RANDOM, PIX_CONST, PIX_RAMP, PIX_RANDOM};
        // Only the long row holds its results back
        t_drain = '{0, 0, 0, 0, 300};
        for (i = 0; i < TAPS; i++) begin
            // Centre tap only
            t_kern[0][i] = (i == TAPS / 2) ? 16'd1 : 16'd0;
            t_kern[1][i] = conv_data_pkg::coef_t'($urandom % 16);
            t_kern[2][i] = 16'd1;
            // Distinct taps so a mixed-up window shows
            t_kern[3][i] = conv_data_pkg::coef_t'(i + 1);
            t_kern[4][i] = conv_data_pkg::coef_t'((i % 3) + 1);
        end
    endtask

    task automatic make_image(input int t);
        int y;
        int x;
        int i;
        int ksum;
        int pmax;
        ksum = 0;
        for (i = 0; i < TAPS; i++) begin
            ksum = ksum + int'(t_kern[t][i]);
        end
        // Random pixels small enough that the weighted sum stays below the clip level
        pmax = (ksum > 0) ? 65535 / ksum : 65535;
        for (y = 0; y < t_h[t]; y++) begin
            for (x = 0; x < t_w[t]; x++) begin
                case (t_mode[t])
                    PIX_CONST: img[y][x] = 16'hFFFF;
                    // Unique per position with the row in the upper bits
                    PIX_RAMP:  img[y][x] = conv_data_pkg::pixel_t'(y * 64 + x + 1);
                    default:   img[y][x] = conv_data_pkg::pixel_t'($urandom % (pmax + 1));
                endcase
            end
        end
    endtask

    // Reference model as column-major dot product clipped to 16 bits
    task automatic build_expected(input int t);
        int     r;
        int     x;
        int     c;
        int     k;
        longint sum;
        exp_q.delete();
        for (r = 0; r + K <= t_h[t]; r++) begin
            for (x = K - 1; x < t_w[t]; x++) begin
                sum = 0;
                for (c = 0; c < K; c++) begin
                    for (k = 0; k < K; k++) begin
                        sum = sum + longint'(t_kern[t][c * K + k]) *
                                    longint'(img[r + k][x - (K - 1) + c]);
                    end
                end
                exp_q.push_back((sum > 64'hFFFF) ? 16'hFFFF : conv_data_pkg::result_t'(sum));
            end
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        arst_n = 1'b0;
        start  = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;
    endtask

    // One word per cycle and held back while the input FIFO is full
    task automatic push_word(input logic nl, input conv_data_pkg::pixel_t d);
        @(posedge clk);
        #1;
        wr      = 1'b0;
        newline = 1'b0;
        while (full_in) begin
            saw_full_in = 1'b1;
            @(posedge clk);
            #1;
        end
        wr      = !nl;
        newline = nl;
        data_in = d;
    endtask

    task automatic write_stream(input int t);
        int i;
        int r;
        int x;
        int k;
        for (i = 0; i < TAPS; i++) begin
            push_word(1'b0, t_kern[t][i]);
        end
        // Each image row as columns of three from top to bottom
        for (r = 0; r + K <= t_h[t]; r++) begin
            for (x = 0; x < t_w[t]; x++) begin
                for (k = 0; k < K; k++) begin
                    push_word(1'b0, img[r + k][x]);
                end
            end
            push_word(1'b1, '0);
        end
        @(posedge clk);
        #1;
        wr      = 1'b0;
        newline = 1'b0;
    endtask

    task automatic read_results(input int t);
        repeat (t_drain[t]) @(posedge clk);
        while (exp_q.size() > 0) begin
            @(posedge clk);
            #1;
            rd = 1'b0;
            if (!empty_out) begin
                check_result("data_out", data_out, exp_q.pop_front());
                rd = 1'b1;
            end
        end
        // Last pop happens on this edge
        @(posedge clk);
        #1;
        rd = 1'b0;
    endtask

    task automatic run_test(input int t);
        int err_before;
        err_before = errors;
        cur_test   = t_name[t];
        apply_reset();
        check_flag("empty_in", empty_in, 1'b1);
        check_flag("empty_out", empty_out, 1'b1);
        check_flag("full_in", full_in, 1'b0);
        check_flag("full_out", full_out, 1'b0);
        make_image(t);
        build_expected(t);
        saw_full_in = 1'b0;
        start       = 1'b1;
        fork
            write_stream(t);
            read_results(t);
        join
        // Nothing left over and no extra results
        repeat (10) @(posedge clk);
        #1;
        check_flag("empty_out", empty_out, 1'b1);
        check_flag("empty_in", empty_in, 1'b1);
        if (t_drain[t] > 0) begin
            check_flag("full_in", saw_full_in, 1'b1);
        end
        start = 1'b0;
        if (errors == err_before) begin
            $display("test %s: passed", cur_test);
            n_pass++;
        end else begin
            $display("test %s: failed with %0d errors", cur_test, errors - err_before);
            n_fail++;
        end
    endtask

    initial begin
        int t;
        int words;
        arst_n       = 1'b0;
        start        = 1'b0;
        wr           = 1'b0;
        newline      = 1'b0;
        data_in      = '0;
        rd           = 1'b0;
        errors       = 0;
        n_pass       = 0;
        n_fail       = 0;
        limit_cycles = 0;
        void'($urandom(31));
        build_table();
        // Kernel plus columns and a newline per image row
        words = 0;
        for (t = 0; t < N_TESTS; t++) begin
            words = words + TAPS + (t_h[t] - 2) * (3 * t_w[t] + 1);
        end
        limit_cycles = words * 20 + t_drain[N_TESTS - 1];
        for (t = 0; t < N_TESTS; t++) begin
            run_test(t);
        end
        $display("Tests passed: %0d, failed: %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+common
common/conv_data_pkg.sv
common/conv_ctrl_pkg.sv
verilog/conv_fifo.sv
convolution/conv_window.sv
convolution/conv_mac.sv
verilog/conv_accelerator.sv
verif/conv_accelerator_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= conv_accelerator_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qxF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
